// File: source/conv_pkg.sv
package conv_pkg;

	////////////////////////////////////////
	// sample format
	////////////////////////////////////////

	// pixel and weight width, both signed
	localparam int DATA_WIDTH = 16;

	// nine signed products summed without loss
	localparam int ACC_WIDTH = 36;

	////////////////////////////////////////
	// kernel
	////////////////////////////////////////

	// taps per 3x3 kernel set
	localparam int KERNEL_SIZE = 9;

	// weight counter, counts 0 to KERNEL_SIZE-1
	localparam int CNT_WIDTH = 4;

	// kernel sets waiting for load_weights
	localparam int WEIGHT_SETS = 2;

	////////////////////////////////////////
	// image geometry
	////////////////////////////////////////

	// pixels per line, also line buffer depth
	localparam int IMAGE_WIDTH = 8;

	// column counter width
	localparam int COL_WIDTH = 3;

endpackage

// File: source/weight_buffer.sv
`timescale 1ns/1ns

module weight_buffer import conv_pkg::*; (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         weight_valid,
	input  logic signed [DATA_WIDTH-1:0] weight_in,
	input  logic                         load_weights,
	output logic signed [DATA_WIDTH-1:0] weight_00,
	output logic signed [DATA_WIDTH-1:0] weight_01,
	output logic signed [DATA_WIDTH-1:0] weight_02,
	output logic signed [DATA_WIDTH-1:0] weight_03,
	output logic signed [DATA_WIDTH-1:0] weight_04,
	output logic signed [DATA_WIDTH-1:0] weight_05,
	output logic signed [DATA_WIDTH-1:0] weight_06,
	output logic signed [DATA_WIDTH-1:0] weight_07,
	output logic signed [DATA_WIDTH-1:0] weight_08,
	output logic                         weights_ready,
	output logic                         weight_full
);

	logic signed [DATA_WIDTH-1:0] chain [KERNEL_SIZE];
	logic signed [DATA_WIDTH-1:0] next_set [KERNEL_SIZE];
	logic signed [DATA_WIDTH-1:0] store [WEIGHT_SETS][KERNEL_SIZE];
	logic signed [DATA_WIDTH-1:0] active [KERNEL_SIZE];
	logic [CNT_WIDTH-1:0] weight_cnt;
	logic [$clog2(WEIGHT_SETS)-1:0] wr_ptr;
	logic [$clog2(WEIGHT_SETS)-1:0] rd_ptr;
	logic [$clog2(WEIGHT_SETS):0] set_cnt;
	logic set_done;
	logic push;
	logic pop;

	// chain contents after this strobe, oldest weight ends up in tap 0
	always_comb begin
		for (int i = 0; i < KERNEL_SIZE - 1; i++)
			next_set[i] = chain[i + 1];
		next_set[KERNEL_SIZE-1] = weight_in;
	end

	assign set_done = weight_valid && (weight_cnt == KERNEL_SIZE - 1);
	// full store drops the new set
	assign push = set_done && (set_cnt < WEIGHT_SETS);
	assign pop = load_weights && (set_cnt != 0);

	////////////////////////////////////////
	// set counter and store pointers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			weight_cnt <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			set_cnt <= '0;
			weights_ready <= 1'b0;
			weight_full <= 1'b0;
		end else begin
			if (weight_valid)
				weight_cnt <= set_done ? '0 : weight_cnt + 1'b1;
			if (push)
				wr_ptr <= (wr_ptr == WEIGHT_SETS - 1) ? '0 : wr_ptr + 1'b1;
			if (pop) begin
				rd_ptr <= (rd_ptr == WEIGHT_SETS - 1) ? '0 : rd_ptr + 1'b1;
				weights_ready <= 1'b1;
			end
			if (push && !pop)
				set_cnt <= set_cnt + 1'b1;
			else if (pop && !push)
				set_cnt <= set_cnt - 1'b1;
			// lags the store count by one cycle
			weight_full <= (set_cnt == WEIGHT_SETS);
		end
	end

	////////////////////////////////////////
	// weight storage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (weight_valid)
			chain <= next_set;
		if (push)
			store[wr_ptr] <= next_set;
		if (pop)
			active <= store[rd_ptr];
	end

	assign weight_00 = active[0];
	assign weight_01 = active[1];
	assign weight_02 = active[2];
	assign weight_03 = active[3];
	assign weight_04 = active[4];
	assign weight_05 = active[5];
	assign weight_06 = active[6];
	assign weight_07 = active[7];
	assign weight_08 = active[8];

endmodule

// File: source/line_window.sv
`timescale 1ns/1ns

module line_window import conv_pkg::*; (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         pixel_valid,
	input  logic                         frame_start,
	input  logic signed [DATA_WIDTH-1:0] pixel_in,
	output logic signed [DATA_WIDTH-1:0] win_00,
	output logic signed [DATA_WIDTH-1:0] win_01,
	output logic signed [DATA_WIDTH-1:0] win_02,
	output logic signed [DATA_WIDTH-1:0] win_03,
	output logic signed [DATA_WIDTH-1:0] win_04,
	output logic signed [DATA_WIDTH-1:0] win_05,
	output logic signed [DATA_WIDTH-1:0] win_06,
	output logic signed [DATA_WIDTH-1:0] win_07,
	output logic signed [DATA_WIDTH-1:0] win_08,
	output logic                         win_valid
);

	// line_0 holds the previous line, line_1 the one before
	logic signed [DATA_WIDTH-1:0] line_0 [IMAGE_WIDTH];
	logic signed [DATA_WIDTH-1:0] line_1 [IMAGE_WIDTH];
	logic signed [DATA_WIDTH-1:0] win [KERNEL_SIZE];
	logic [COL_WIDTH-1:0] col;
	logic [COL_WIDTH-1:0] cur_col;
	// row only has to tell 0, 1 and 2 or more apart
	logic [1:0] row;
	logic [1:0] cur_row;

	// position of the pixel on the bus, frame_start forces 0,0
	assign cur_col = frame_start ? '0 : col;
	assign cur_row = frame_start ? '0 : row;

	////////////////////////////////////////
	// position counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
			win_valid <= 1'b0;
		end else begin
			win_valid <= pixel_valid && (cur_row == 2'd2) && (cur_col >= 2);
			if (pixel_valid) begin
				if (cur_col == IMAGE_WIDTH - 1) begin
					col <= '0;
					// saturate, rows never wrap
					row <= (cur_row == 2'd2) ? cur_row : cur_row + 1'b1;
				end else begin
					col <= cur_col + 1'b1;
					row <= cur_row;
				end
			end
		end
	end

	////////////////////////////////////////
	// line buffers and window
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			line_1[cur_col] <= line_0[cur_col];
			line_0[cur_col] <= pixel_in;
			// top row, oldest line
			win[0] <= win[1];
			win[1] <= win[2];
			win[2] <= line_1[cur_col];
			// middle row
			win[3] <= win[4];
			win[4] <= win[5];
			win[5] <= line_0[cur_col];
			// bottom row, current line
			win[6] <= win[7];
			win[7] <= win[8];
			win[8] <= pixel_in;
		end
	end

	assign win_00 = win[0];
	assign win_01 = win[1];
	assign win_02 = win[2];
	assign win_03 = win[3];
	assign win_04 = win[4];
	assign win_05 = win[5];
	assign win_06 = win[6];
	assign win_07 = win[7];
	assign win_08 = win[8];

endmodule

// File: source/mac_3x3.sv
`timescale 1ns/1ns

module mac_3x3 import conv_pkg::*; (
	input  logic                         clk,
	input  logic                         reset,
	input  logic signed [DATA_WIDTH-1:0] win_00,
	input  logic signed [DATA_WIDTH-1:0] win_01,
	input  logic signed [DATA_WIDTH-1:0] win_02,
	input  logic signed [DATA_WIDTH-1:0] win_03,
	input  logic signed [DATA_WIDTH-1:0] win_04,
	input  logic signed [DATA_WIDTH-1:0] win_05,
	input  logic signed [DATA_WIDTH-1:0] win_06,
	input  logic signed [DATA_WIDTH-1:0] win_07,
	input  logic signed [DATA_WIDTH-1:0] win_08,
	input  logic                         win_valid,
	input  logic signed [DATA_WIDTH-1:0] weight_00,
	input  logic signed [DATA_WIDTH-1:0] weight_01,
	input  logic signed [DATA_WIDTH-1:0] weight_02,
	input  logic signed [DATA_WIDTH-1:0] weight_03,
	input  logic signed [DATA_WIDTH-1:0] weight_04,
	input  logic signed [DATA_WIDTH-1:0] weight_05,
	input  logic signed [DATA_WIDTH-1:0] weight_06,
	input  logic signed [DATA_WIDTH-1:0] weight_07,
	input  logic signed [DATA_WIDTH-1:0] weight_08,
	input  logic                         weights_ready,
	output logic signed [ACC_WIDTH-1:0]  result,
	output logic                         result_valid
);

	logic signed [DATA_WIDTH-1:0] pix [KERNEL_SIZE];
	logic signed [DATA_WIDTH-1:0] coef [KERNEL_SIZE];
	logic signed [2*DATA_WIDTH-1:0] prod [KERNEL_SIZE];
	logic signed [ACC_WIDTH-1:0] sum;
	logic prod_valid;

	assign pix = '{win_00, win_01, win_02, win_03, win_04,
		win_05, win_06, win_07, win_08};
	assign coef = '{weight_00, weight_01, weight_02, weight_03, weight_04,
		weight_05, weight_06, weight_07, weight_08};

	////////////////////////////////////////
	// stage 1, products
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int k = 0; k < KERNEL_SIZE; k++)
			prod[k] <= pix[k] * coef[k];
	end

	////////////////////////////////////////
	// stage 2, sum
	////////////////////////////////////////

	// products sign-extend into the wide sum
	always_comb begin
		sum = '0;
		for (int k = 0; k < KERNEL_SIZE; k++)
			sum = sum + prod[k];
	end

	always_ff @(posedge clk) begin
		result <= sum;
	end

	// windows seen before the first load are dropped here
	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			prod_valid <= win_valid && weights_ready;
			result_valid <= prod_valid;
		end
	end

endmodule

// File: source/conv_3x3_top.sv
`timescale 1ns/1ns

module conv_3x3_top import conv_pkg::*; (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         weight_valid,
	input  logic signed [DATA_WIDTH-1:0] weight_in,
	input  logic                         load_weights,
	input  logic                         pixel_valid,
	input  logic                         frame_start,
	input  logic signed [DATA_WIDTH-1:0] pixel_in,
	output logic signed [ACC_WIDTH-1:0]  result,
	output logic                         result_valid,
	output logic                         weights_ready,
	output logic                         weight_full
);

	// active kernel taps
	logic signed [DATA_WIDTH-1:0] weight_00, weight_01, weight_02;
	logic signed [DATA_WIDTH-1:0] weight_03, weight_04, weight_05;
	logic signed [DATA_WIDTH-1:0] weight_06, weight_07, weight_08;

	// current 3x3 window, raster order
	logic signed [DATA_WIDTH-1:0] win_00, win_01, win_02;
	logic signed [DATA_WIDTH-1:0] win_03, win_04, win_05;
	logic signed [DATA_WIDTH-1:0] win_06, win_07, win_08;
	logic win_valid;

	weight_buffer u_weight_buffer (
		.clk, .reset, .weight_valid, .weight_in, .load_weights,
		.weight_00, .weight_01, .weight_02, .weight_03, .weight_04,
		.weight_05, .weight_06, .weight_07, .weight_08,
		.weights_ready, .weight_full
	);

	line_window u_line_window (
		.clk, .reset, .pixel_valid, .frame_start, .pixel_in,
		.win_00, .win_01, .win_02, .win_03, .win_04,
		.win_05, .win_06, .win_07, .win_08,
		.win_valid
	);

	mac_3x3 u_mac_3x3 (
		.clk, .reset,
		.win_00, .win_01, .win_02, .win_03, .win_04,
		.win_05, .win_06, .win_07, .win_08, .win_valid,
		.weight_00, .weight_01, .weight_02, .weight_03, .weight_04,
		.weight_05, .weight_06, .weight_07, .weight_08, .weights_ready,
		.result, .result_valid
	);

endmodule

// File: bench/conv_checker.sv
`timescale 1ns/1ns

module conv_checker import conv_pkg::*; (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         weight_valid,
	input  logic signed [DATA_WIDTH-1:0] weight_in,
	input  logic                         load_weights,
	input  logic                         pixel_valid,
	input  logic                         frame_start,
	input  logic signed [DATA_WIDTH-1:0] pixel_in,
	input  logic signed [ACC_WIDTH-1:0]  result,
	input  logic                         result_valid,
	input  logic                         weights_ready,
	input  logic                         weight_full,
	output int                           errors,
	output int                           checks,
	output int                           pending
);

	// two kernel sets wait for load_weights
	localparam int STORE_DEPTH = 2;
	localparam int MAX_ROWS = 16;
	// completing pixel to result_valid
	localparam int LATENCY = 3;

	logic signed [DATA_WIDTH-1:0] img [MAX_ROWS][IMAGE_WIDTH];
	logic signed [DATA_WIDTH-1:0] received [KERNEL_SIZE];
	logic signed [DATA_WIDTH-1:0] active [KERNEL_SIZE];
	logic [KERNEL_SIZE*DATA_WIDTH-1:0] sets [$];
	logic signed [ACC_WIDTH-1:0] exp_val [$];
	int exp_due [$];
	int cycle;
	int wcnt;
	int row;
	int col;
	logic ready;
	logic full;

	always @(posedge clk) begin : model
		logic [KERNEL_SIZE*DATA_WIDTH-1:0] packed_set;
		longint acc;
		int pre_size;
		if (reset) begin
			cycle = 0;
			wcnt = 0;
			row = 0;
			col = 0;
			ready = 1'b0;
			full = 1'b0;
			sets.delete();
			exp_val.delete();
			exp_due.delete();
			errors = 0;
			checks = 0;
		end else begin
			cycle++;
			pre_size = sets.size();

			////////////////////////////////////////
			// flags, values from before this edge
			////////////////////////////////////////
			checks += 2;
			if (weights_ready !== ready) begin
				errors++;
				$display("FAILED at %0t ns: weights_ready %b, expected %b",
					$time, weights_ready, ready);
			end
			if (weight_full !== full) begin
				errors++;
				$display("FAILED at %0t ns: weight_full %b, expected %b",
					$time, weight_full, full);
			end
			// full flag trails the store count by a cycle
			full = (pre_size == STORE_DEPTH);

			////////////////////////////////////////
			// results
			////////////////////////////////////////
			if (result_valid === 1'b1) begin
				if (exp_val.size() == 0) begin
					errors++;
					$display("unexpected result %0d at %0t ns, no window was pending",
						result, $time);
				end else begin
					checks++;
					if (exp_due[0] != cycle) begin
						errors++;
						$display("result at %0t ns came %0d cycles away from its slot",
							$time, cycle - exp_due[0]);
					end
					if (result !== exp_val[0]) begin
						errors++;
						$display("FAILED at %0t ns: result %0d, expected %0d",
							$time, result, exp_val[0]);
					end
					exp_val.pop_front();
					exp_due.pop_front();
				end
			end else if (exp_val.size() != 0 && exp_due[0] <= cycle) begin
				errors++;
				$display("missing result at %0t ns, expected %0d", $time, exp_val[0]);
				exp_val.pop_front();
				exp_due.pop_front();
			end

			////////////////////////////////////////
			// weights, first received is tap 0
			////////////////////////////////////////
			if (weight_valid) begin
				received[wcnt] = weight_in;
				wcnt++;
				if (wcnt == KERNEL_SIZE) begin
					wcnt = 0;
					for (int k = 0; k < KERNEL_SIZE; k++)
						packed_set[k*DATA_WIDTH +: DATA_WIDTH] = received[k];
					// a full store loses the new set
					if (pre_size < STORE_DEPTH)
						sets.push_back(packed_set);
				end
			end
			if (load_weights && pre_size != 0) begin
				packed_set = sets.pop_front();
				for (int k = 0; k < KERNEL_SIZE; k++)
					active[k] = packed_set[k*DATA_WIDTH +: DATA_WIDTH];
				ready = 1'b1;
			end

			////////////////////////////////////////
			// pixels and windows
			////////////////////////////////////////
			if (pixel_valid) begin
				if (frame_start) begin
					row = 0;
					col = 0;
				end
				img[row][col] = pixel_in;
				if (ready && row >= 2 && col >= 2) begin
					acc = 0;
					for (int k = 0; k < KERNEL_SIZE; k++)
						acc += longint'(active[k]) * longint'(img[row-2+k/3][col-2+k%3]);
					exp_val.push_back(acc[ACC_WIDTH-1:0]);
					exp_due.push_back(cycle + LATENCY);
				end
				col++;
				if (col == IMAGE_WIDTH) begin
					col = 0;
					if (row < MAX_ROWS - 1)
						row++;
				end
			end
		end
		pending = exp_val.size();
	end

endmodule

// File: bench/conv_tb.sv
`timescale 1ns/1ns

module conv_tb import conv_pkg::*; ();

	// worst case stimulus length per test, gaps counted at three cycles
	localparam int TEST1_CYCLES = 6 * IMAGE_WIDTH + 10;
	localparam int TEST2_CYCLES = KERNEL_SIZE + 6 * IMAGE_WIDTH + 16;
	localparam int TEST3_CYCLES = 3 * KERNEL_SIZE + 3 * 4 * IMAGE_WIDTH + 40;
	localparam int TEST4_CYCLES = 4 * 6 * IMAGE_WIDTH + 10;
	localparam int TEST5_CYCLES = 9 * IMAGE_WIDTH + 3 + 10;
	localparam int LIMIT = 2 + TEST1_CYCLES + TEST2_CYCLES + TEST3_CYCLES
		+ TEST4_CYCLES + TEST5_CYCLES + 100;

	logic clk;
	logic reset;
	logic weight_valid;
	logic signed [DATA_WIDTH-1:0] weight_in;
	logic load_weights;
	logic pixel_valid;
	logic frame_start;
	logic signed [DATA_WIDTH-1:0] pixel_in;
	logic signed [ACC_WIDTH-1:0] result;
	logic result_valid;
	logic weights_ready;
	logic weight_full;
	int errors;
	int checks;
	int pending;
	int last_errors = 0;
	int cycle = 0;
	logic [31:0] rng = 32'd52;

	conv_3x3_top UUT (
		.clk, .reset, .weight_valid, .weight_in, .load_weights,
		.pixel_valid, .frame_start, .pixel_in,
		.result, .result_valid, .weights_ready, .weight_full
	);

	conv_checker u_checker (
		.clk, .reset, .weight_valid, .weight_in, .load_weights,
		.pixel_valid, .frame_start, .pixel_in,
		.result, .result_valid, .weights_ready, .weight_full,
		.errors, .checks, .pending
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("timeout, the tests did not finish within %0d cycles", LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	// xorshift32
	function logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic send_weight_set();
		logic [31:0] r;
		repeat (KERNEL_SIZE) begin
			r = next_rand();
			@(posedge clk);
			weight_valid <= 1'b1;
			weight_in <= r[DATA_WIDTH-1:0];
		end
		@(posedge clk);
		weight_valid <= 1'b0;
	endtask

	task automatic pulse_load();
		@(posedge clk);
		load_weights <= 1'b1;
		@(posedge clk);
		load_weights <= 1'b0;
	endtask

	// first pixel carries frame_start
	task automatic send_pixels(input int count, input logic gaps);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			r = next_rand();
			if (gaps) begin
				repeat (r[17:16]) begin
					@(posedge clk);
					pixel_valid <= 1'b0;
					frame_start <= 1'b0;
				end
			end
			@(posedge clk);
			pixel_valid <= 1'b1;
			frame_start <= (i == 0);
			pixel_in <= r[DATA_WIDTH-1:0];
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
		frame_start <= 1'b0;
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d, %s: done with %0d errors", num, name, errors - last_errors);
		last_errors = errors;
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		reset <= 1'b1;
		weight_valid <= 1'b0;
		weight_in <= '0;
		load_weights <= 1'b0;
		pixel_valid <= 1'b0;
		frame_start <= 1'b0;
		pixel_in <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		send_pixels(6 * IMAGE_WIDTH, 1'b0);
		idle(4);
		end_test(1, "frame before any weight load");

		send_weight_set();
		pulse_load();
		send_pixels(6 * IMAGE_WIDTH, 1'b0);
		idle(4);
		end_test(2, "one set, frame without gaps");

		// two queued, the third is dropped
		send_weight_set();
		send_weight_set();
		idle(2);
		send_weight_set();
		repeat (3) begin
			pulse_load();
			send_pixels(4 * IMAGE_WIDTH, 1'b0);
			idle(4);
		end
		end_test(3, "set store order and overflow");

		send_pixels(6 * IMAGE_WIDTH, 1'b1);
		idle(4);
		end_test(4, "random gaps in pixel_valid");

		// restart three pixels into the fifth line
		send_pixels(4 * IMAGE_WIDTH + 3, 1'b0);
		send_pixels(5 * IMAGE_WIDTH, 1'b0);
		idle(4);
		end_test(5, "frame_start in mid frame");

		idle(4);
		$display("%0d checks, %0d errors, %0d results pending", checks, errors, pending);
		if (errors == 0 && pending == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
source/conv_pkg.sv
source/weight_buffer.sv
source/line_window.sv
source/mac_3x3.sv
source/conv_3x3_top.sv
bench/conv_checker.sv
bench/conv_tb.sv

// File: run.sh
#!/bin/sh
# build and run the convolution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f list.f --top-module conv_tb -o conv_sim

out=$(./obj_dir/conv_sim)
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
else
	exit 1
fi
